// File: sim.f
+incdir+verilog
verilog/rvvi_pkg.sv
verilog/retire_monitor.sv
verilog/net_tracker.sv
verilog/net_event_arbiter.sv
verilog/rvfi_to_rvvi.sv
verification/rvfi_to_rvvi_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it; a $fatal in the run gives a failing status
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
   -f sim.f \
   --top-module rvfi_to_rvvi_tb \
   -o rvfi_to_rvvi_sim

./obj_dir/rvfi_to_rvvi_sim

// File: verification/rvfi_to_rvvi_tb.sv
// Checks trace one cycle after a retirement and net events only by level alternation and final level
`timescale 1ns/1ns
`include "rvvi_cfg.svh"

module rvfi_to_rvvi_tb;
   import rvvi_pkg::*;

   localparam int NN        = `RVVI_NUM_NETS;
   localparam int CW        = 300;
   localparam int SETTLE    = 2 * NN + 4;
   localparam int N_RAND    = 200;
   localparam int N_REPEAT  = 20;
   localparam int N_TRAP    = 40;
   localparam int N_SPACED  = 30;
   localparam int N_CASES   = 8;
   localparam int N_BURST   = 40;
   localparam int TEST_CYCLES = 3 + N_RAND + 2 * N_REPEAT + N_TRAP + SETTLE +
      N_SPACED * (NN + 4) + N_CASES * (SETTLE + 1) + N_BURST + SETTLE;
   localparam int CYCLE_LIMIT = TEST_CYCLES + 200;

   logic                          rvvi;
   logic                          arst_n;
   rvfi_retire_t                  retire;
   logic [`RVVI_XLEN-1:0]         irq;
   rvvi_trace_t                   trace;
   net_event_t                    net_event;
   logic [`RVVI_INTR_CAUSE_W-1:0] nmi_cause;

   // Reference state
   logic [31:0]                   lfsr = 32'h1914;
   logic [`RVVI_ORDER_W-1:0]      next_order = '0;
   logic [`RVVI_ORDER_W-1:0]      ref_last_order = '0;
   logic [NN-1:0]                 ref_levels = '0;
   logic [`RVVI_INTR_CAUSE_W-1:0] ref_nmi_cause = '0;
   logic [NN-1:0]                 reported = '0;
   int                            ev_count[NN];
   int                            ev_total = 0;
   int                            cycles = 0;
   rvvi_trace_t                   exp_q[$];
   time                           exp_t[$];
   logic [`RVVI_XLEN-1:0]         cur_irq;

   rvfi_to_rvvi dut0 (
      .rvvi      (rvvi),
      .arst_n    (arst_n),
      .retire    (retire),
      .irq       (irq),
      .trace     (trace),
      .net_event (net_event),
      .nmi_cause (nmi_cause)
   );

   initial begin
      rvvi = 1'b0;
      forever #10 rvvi = ~rvvi;
   end

   //////////////////////////////
   // Random source and reference

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h80200003 : 32'h0);
         r = {r[30:0], lfsr[0]};
      end
      return r;
   endfunction

   function automatic int irq_bit_of(input int net);
      case (net)
         NET_MSW_IRQ:    return 3;
         NET_MTIMER_IRQ: return 7;
         NET_MEXT_IRQ:   return 11;
         default:        return 16 + net - NET_LOCAL_IRQ_BASE;
      endcase
   endfunction

   function automatic logic nmi_rule(input rvfi_retire_t r);
      return (r.intr.intr && r.intr.interrupt &&
              (r.intr.cause == 11'd1024 || r.intr.cause == 11'd1025)) || r.nmip[0];
   endfunction

   function automatic rvvi_trace_t expect_trace(input rvfi_retire_t r);
      rvvi_trace_t e;
      e          = '0;
      e.valid    = 1'b1;
      e.order    = r.order;
      e.insn     = r.insn;
      e.trap     = r.trap.trap && (r.trap.exception_cause == 6'd48);
      e.intr     = r.intr.intr;
      e.mode     = r.mode;
      e.ixl      = r.ixl;
      e.pc_rdata = r.pc_rdata;
      e.pc_wdata = r.pc_wdata;
      for (int i = 1; i < 32; i++) begin
         e.x_wb[i] = (r.rd1_addr == 5'(i));
      end
      e.x_wdata  = r.rd1_wdata;
      return e;
   endfunction

   function automatic logic [NN-1:0] next_levels(input logic [NN-1:0] prev,
         input rvfi_retire_t r, input logic [31:0] irq_v, input logic is_new);
      logic [NN-1:0] l;
      l = prev;
      for (int n = NET_MSW_IRQ; n < NN; n++) begin
         l[n] = irq_v[irq_bit_of(n)];
      end
      if (is_new) begin
         l[NET_NMI]        = nmi_rule(r);
         l[NET_IBUS_FAULT] = r.trap.trap && r.trap.exception &&
                             (r.trap.exception_cause == 6'd48);
         l[NET_HALTREQ]    = (r.dbg == DBG_CAUSE_HALTREQ) && r.dbg_mode;
      end
      return l;
   endfunction

   function automatic rvfi_retire_t random_retire(input logic force_trap);
      rvfi_retire_t r;
      r = '0;
      next_order = next_order + `RVVI_ORDER_W'(rand_bits(3)) + 1'b1;
      r.valid     = 1'b1;
      r.order     = next_order;
      r.insn      = rand_bits(32);
      r.pc_rdata  = rand_bits(32);
      r.pc_wdata  = rand_bits(32);
      r.rd1_wdata = rand_bits(32);
      r.rd1_addr  = (rand_bits(3) == 0) ? 5'd0 : 5'(rand_bits(5));
      r.mode      = 2'(rand_bits(2));
      r.ixl       = 2'(rand_bits(2));
      r.trap.trap = force_trap || (rand_bits(3) == 0);
      r.trap.exception       = 1'(rand_bits(1));
      r.trap.exception_cause = (rand_bits(1) != 0) ? 6'd48 : 6'(rand_bits(6));
      r.intr.intr      = (rand_bits(3) == 0);
      r.intr.interrupt = 1'(rand_bits(1));
      r.intr.cause     = (rand_bits(1) != 0) ? 11'(1024 + rand_bits(1)) : 11'(rand_bits(11));
      r.nmip      = (rand_bits(4) == 0) ? 2'(rand_bits(2)) : 2'b00;
      r.dbg       = 3'(rand_bits(3));
      r.dbg_mode  = 1'(rand_bits(1));
      return r;
   endfunction

   // Directed retirements for NMI, bus fault and halt request
   function automatic rvfi_retire_t build_case(input int k);
      rvfi_retire_t r;
      r = '0;
      next_order = next_order + 1'b1;
      r.valid = 1'b1;
      r.order = next_order;
      case (k)
         0: r.intr = '{intr: 1'b1, interrupt: 1'b1, cause: 11'd1024};
         2: r.intr = '{intr: 1'b1, interrupt: 1'b1, cause: 11'd1025};
         3: begin
            r.nmip       = 2'b01;
            r.intr.cause = 11'd5;
         end
         4: r.trap = '{trap: 1'b1, exception: 1'b1, debug: 1'b0, exception_cause: 6'd48};
         5: r.dbg_mode = 1'b1;
         6: r.dbg = 3'd3;
         7: r.intr = '{intr: 1'b1, interrupt: 1'b0, cause: 11'd1024};
         default: ;
      endcase
      if (k == 5) begin
         r.dbg = 3'd3;
      end
      return r;
   endfunction

   //////////////////////////////
   // Drive and compare

   task automatic check(input logic [CW-1:0] got, input logic [CW-1:0] exp,
         input string what);
      if (got !== exp) begin
         $display("[FAIL] %0t ns: %s got %0h expected %0h", $time, what, got, exp);
         $display("STATUS: FAIL");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic drive_cycle(input rvfi_retire_t r, input logic [31:0] irq_v);
      rvvi_trace_t e;
      logic        is_new;
      @(negedge rvvi);
      retire = r;
      irq    = irq_v;
      is_new = r.valid && (r.order != ref_last_order);
      e      = is_new ? expect_trace(r) : '0;
      ref_levels = next_levels(ref_levels, r, irq_v, is_new);
      if (is_new && nmi_rule(r)) begin
         ref_nmi_cause = r.intr.cause;
      end
      if (is_new) begin
         ref_last_order = r.order;
      end
      exp_q.push_back(e);
      exp_t.push_back($time);
   endtask

   task automatic idle(input int n);
      repeat (n) drive_cycle('0, cur_irq);
   endtask

   task automatic check_settled(input string what);
      idle(SETTLE);
      #1;
      check(CW'(reported), CW'(ref_levels), {what, " reported levels"});
      check(CW'(nmi_cause), CW'(ref_nmi_cause), {what, " nmi_cause"});
   endtask

   always @(negedge rvvi) begin : compare_outputs
      rvvi_trace_t e;
      if (arst_n) begin
         if (exp_q.size() > 0 && exp_t[0] < $time) begin
            e = exp_q.pop_front();
            void'(exp_t.pop_front());
            check(CW'(trace.valid), CW'(e.valid), "trace.valid");
            if (e.valid) begin
               check(CW'(trace), CW'(e), "trace record");
            end
         end
         if (net_event.valid) begin
            check(CW'(net_event.id < NN), CW'(1), "event id in range");
            check(CW'(net_event.level), CW'(!reported[net_event.id]), "event level alternation");
            reported[net_event.id] = net_event.level;
            ev_count[net_event.id]++;
            ev_total++;
         end
      end
   end

   always @(posedge rvvi) begin
      cycles++;
      if (cycles > CYCLE_LIMIT) begin
         $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("STATUS: FAIL");
         $fatal(1, "timeout");
      end
   end

   //////////////////////////////
   // Test sequence

   initial begin : run_tests
      rvfi_retire_t r;
      int           net;
      int           cnt_before;
      int           tot_before;
      arst_n  = 1'b0;
      retire  = '0;
      irq     = '0;
      cur_irq = '0;
      for (int n = 0; n < NN; n++) ev_count[n] = 0;
      repeat (2) @(posedge rvvi);
      @(negedge rvvi);
      arst_n = 1'b1;

      // Trace forwarding with random destinations
      for (int i = 0; i < N_RAND; i++) drive_cycle(random_retire(1'b0), cur_irq);

      // Repeated order gives no trace strobe
      for (int i = 0; i < N_REPEAT; i++) begin
         r = random_retire(1'b0);
         drive_cycle(r, cur_irq);
         r.insn = rand_bits(32);
         drive_cycle(r, cur_irq);
      end

      // Trap filter
      for (int i = 0; i < N_TRAP; i++) drive_cycle(random_retire(1'b1), cur_irq);
      check_settled("after retirements");

      // Spaced single-net changes
      for (int i = 0; i < N_SPACED; i++) begin
         net = NET_MSW_IRQ + int'(rand_bits(8)) % (NN - NET_MSW_IRQ);
         cnt_before = ev_count[net];
         tot_before = ev_total;
         cur_irq[irq_bit_of(net)] = ~cur_irq[irq_bit_of(net)];
         drive_cycle('0, cur_irq);
         idle(NN + 3);
         #1;
         check(CW'(ev_count[net] - cnt_before), CW'(1), "events for changed net");
         check(CW'(ev_total - tot_before), CW'(1), "events in total");
         check(CW'(reported[net]), CW'(ref_levels[net]), "spaced change level");
      end

      // NMI, bus fault and halt request
      for (int k = 0; k < N_CASES; k++) begin
         drive_cycle(build_case(k), cur_irq);
         check_settled("derived net case");
      end

      // Burst of simultaneous irq changes, then quiet
      for (int i = 0; i < N_BURST; i++) begin
         for (int n = NET_MSW_IRQ; n < NN; n++) begin
            if (rand_bits(2) == 0) cur_irq[irq_bit_of(n)] = ~cur_irq[irq_bit_of(n)];
         end
         drive_cycle('0, cur_irq);
      end
      check_settled("after burst");

      // The last idle cycle is compared on the next falling edge
      @(negedge rvvi);
      #1;
      check(CW'(exp_q.size()), CW'(0), "pending trace checks");

      $display("STATUS: PASS");
      $finish;
   end

endmodule

// File: verilog/rvfi_to_rvvi.sv
// One hart, one retirement per cycle; retire and irq must already be synchronous to rvvi
`timescale 1ns/1ns
`include "rvvi_cfg.svh"

module rvfi_to_rvvi (
   input  logic                          rvvi,
   input  logic                          arst_n,
   input  rvvi_pkg::rvfi_retire_t        retire,
   input  logic [`RVVI_XLEN-1:0]         irq,
   output rvvi_pkg::rvvi_trace_t         trace,
   output rvvi_pkg::net_event_t          net_event,
   output logic [`RVVI_INTR_CAUSE_W-1:0] nmi_cause
);

   // Net index order
   // 0 nmi, 1 bus fault, 2 halt request, 3 to 5 machine irqs, then local irqs
   logic [`RVVI_NUM_NETS-1:0] levels;
   logic [`RVVI_NUM_NETS-1:0] pending;
   logic [`RVVI_NUM_NETS-1:0] grant;

   //////////////////////////////
   // Retirement side

   retire_monitor monitor0 (
      .rvvi      (rvvi),
      .arst_n    (arst_n),
      .retire    (retire),
      .irq       (irq),
      .trace     (trace),
      .levels    (levels),
      .nmi_cause (nmi_cause)
   );

   //////////////////////////////
   // Net trackers

   // One tracker per net, all share the same grant vector
   for (genvar g = 0; g < `RVVI_NUM_NETS; g++) begin : g_net
      net_tracker tracker0 (
         .rvvi    (rvvi),
         .arst_n  (arst_n),
         .level   (levels[g]),
         .grant   (grant[g]),
         .pending (pending[g])
      );
   end

   //////////////////////////////
   // Event serializer

   net_event_arbiter arbiter0 (
      .rvvi      (rvvi),
      .arst_n    (arst_n),
      .pending   (pending),
      .levels    (levels),
      .grant     (grant),
      .net_event (net_event)
   );

endmodule

// File: verilog/net_event_arbiter.sv
// Fixed priority, so a net that toggles every cycle can starve all higher-numbered nets
`timescale 1ns/1ns
`include "rvvi_cfg.svh"

module net_event_arbiter (
   input  logic                      rvvi,
   input  logic                      arst_n,
   input  logic [`RVVI_NUM_NETS-1:0] pending,
   input  logic [`RVVI_NUM_NETS-1:0] levels,
   output logic [`RVVI_NUM_NETS-1:0] grant,
   output rvvi_pkg::net_event_t      net_event
);

   localparam int NUM_NETS = `RVVI_NUM_NETS;
   localparam int ID_W     = `RVVI_NET_ID_W;

   logic [ID_W-1:0] pick_id;
   logic            pick_level;
   logic            event_valid_q;
   logic [ID_W-1:0] event_id_q;
   logic            event_level_q;

   //////////////////////////////
   // Pick

   // Lowest set bit of pending wins
   assign grant = pending & (~pending + 1'b1);

   always_comb begin
      pick_id = '0;
      for (int i = 0; i < NUM_NETS; i++) begin
         if (grant[i]) begin
            pick_id = ID_W'(i);
         end
      end
   end

   assign pick_level = |(grant & levels);

   //////////////////////////////
   // Event register

   always_ff @(posedge rvvi or negedge arst_n) begin
      if (!arst_n) begin
         event_valid_q <= 1'b0;
      end else begin
         event_valid_q <= |pending;
      end
   end

   always_ff @(posedge rvvi) begin
      if (|pending) begin
         event_id_q    <= pick_id;
         event_level_q <= pick_level;
      end
   end

   always_comb begin
      net_event.valid = event_valid_q;
      net_event.id    = event_id_q;
      net_event.level = event_level_q;
   end

   // A granted net drops its change unless its level moved again on the same edge
   a_grant_clears_pending: assert property (
      @(posedge rvvi) disable iff (!arst_n)
      (|grant) |=> ((pending & $past(grant) & ~(levels ^ $past(levels))) == '0)
   );

endmodule

// File: verilog/net_tracker.sv
// Level must be synchronous to rvvi; a glitch that reverts before its grant is never reported
`timescale 1ns/1ns

module net_tracker (
   input  logic rvvi,
   input  logic arst_n,
   input  logic level,
   input  logic grant,
   output logic pending
);

   //////////////////////////////
   // Reported level

   // Last level sent downstream, every net starts out low
   logic reported_q;

   always_ff @(posedge rvvi or negedge arst_n) begin
      if (!arst_n) begin
         reported_q <= 1'b0;
      end else if (grant) begin
         // The event for this net leaves on the same edge
         reported_q <= level;
      end
   end

   //////////////////////////////
   // Change detect

   // Stays high until the arbiter picks this net or the level flips back
   assign pending = level ^ reported_q;

   // The arbiter only ever picks a net that has a change waiting
   a_grant_only_when_pending: assert property (
      @(posedge rvvi) disable iff (!arst_n)
      grant |-> pending
   );

endmodule

// File: verilog/retire_monitor.sv
// A retirement whose order equals the last accepted one is dropped, so order 0 is ignored after reset
`timescale 1ns/1ns
`include "rvvi_cfg.svh"

module retire_monitor (
   input  logic                          rvvi,
   input  logic                          arst_n,
   input  rvvi_pkg::rvfi_retire_t        retire,
   input  logic [`RVVI_XLEN-1:0]         irq,
   output rvvi_pkg::rvvi_trace_t         trace,
   output logic [`RVVI_NUM_NETS-1:0]     levels,
   output logic [`RVVI_INTR_CAUSE_W-1:0] nmi_cause
);
   import rvvi_pkg::*;

   // Machine interrupt positions in irq, as in mip
   localparam int MSW_IRQ_BIT    = 3;
   localparam int MTIMER_IRQ_BIT = 7;
   localparam int MEXT_IRQ_BIT   = 11;
   localparam int LOCAL_IRQ_LSB  = 16;

   logic [`RVVI_ORDER_W-1:0]      last_order_q;
   logic                          new_ret;
   logic                          trap_ibus;
   logic                          nmi_hit;
   logic                          ibus_fault_hit;
   logic                          haltreq_hit;
   logic [31:0]                   x_wb_d;
   logic                          trace_valid_q;
   rvvi_trace_t                   trace_q;
   logic [`RVVI_NUM_NETS-1:0]     levels_d;
   logic [`RVVI_NUM_NETS-1:0]     levels_q;
   logic [`RVVI_INTR_CAUSE_W-1:0] nmi_cause_q;

   //////////////////////////////
   // Retirement acceptance

   assign new_ret = retire.valid && (retire.order != last_order_q);

   always_ff @(posedge rvvi or negedge arst_n) begin
      if (!arst_n) begin
         last_order_q <= '0;
      end else if (new_ret) begin
         last_order_q <= retire.order;
      end
   end

   //////////////////////////////
   // Trace record

   // Only the externally caused fetch fault is a trap for the reference model
   assign trap_ibus = retire.trap.trap &&
      (retire.trap.exception_cause == `RVVI_EXC_CAUSE_W'(`RVVI_IBUS_FAULT_CAUSE));

   assign x_wb_d = (retire.rd1_addr == 5'd0) ? 32'd0 : (32'd1 << retire.rd1_addr);

   always_ff @(posedge rvvi or negedge arst_n) begin
      if (!arst_n) begin
         trace_valid_q <= 1'b0;
      end else begin
         trace_valid_q <= new_ret;
      end
   end

   always_ff @(posedge rvvi) begin
      if (new_ret) begin
         trace_q.valid    <= 1'b1;
         trace_q.order    <= retire.order;
         trace_q.insn     <= retire.insn;
         trace_q.trap     <= trap_ibus;
         trace_q.intr     <= retire.intr.intr;
         trace_q.mode     <= retire.mode;
         trace_q.ixl      <= retire.ixl;
         trace_q.pc_rdata <= retire.pc_rdata;
         trace_q.pc_wdata <= retire.pc_wdata;
         trace_q.x_wb     <= x_wb_d;
         trace_q.x_wdata  <= retire.rd1_wdata;
      end
   end

   always_comb begin
      trace       = trace_q;
      trace.valid = trace_valid_q;
   end

   //////////////////////////////
   // Net levels

   // Load or store error NMI, either taken or still pending
   assign nmi_hit = (retire.intr.intr && retire.intr.interrupt &&
                     ((retire.intr.cause == `RVVI_INTR_CAUSE_W'(`RVVI_NMI_LOAD_CAUSE)) ||
                      (retire.intr.cause == `RVVI_INTR_CAUSE_W'(`RVVI_NMI_STORE_CAUSE)))) ||
                    retire.nmip[0];

   assign ibus_fault_hit = retire.trap.trap && retire.trap.exception &&
      (retire.trap.exception_cause == `RVVI_EXC_CAUSE_W'(`RVVI_IBUS_FAULT_CAUSE));

   assign haltreq_hit = (retire.dbg == DBG_CAUSE_HALTREQ) && retire.dbg_mode;

   always_comb begin
      levels_d = levels_q;
      // Interrupt lines follow irq every cycle
      levels_d[NET_MSW_IRQ]    = irq[MSW_IRQ_BIT];
      levels_d[NET_MTIMER_IRQ] = irq[MTIMER_IRQ_BIT];
      levels_d[NET_MEXT_IRQ]   = irq[MEXT_IRQ_BIT];
      for (int i = 0; i < `RVVI_NUM_LOCAL_IRQ; i++) begin
         levels_d[NET_LOCAL_IRQ_BASE + i] = irq[LOCAL_IRQ_LSB + i];
      end
      // Derived nets only move on a new retirement
      if (new_ret) begin
         levels_d[NET_NMI]        = nmi_hit;
         levels_d[NET_IBUS_FAULT] = ibus_fault_hit;
         levels_d[NET_HALTREQ]    = haltreq_hit;
      end
   end

   always_ff @(posedge rvvi or negedge arst_n) begin
      if (!arst_n) begin
         levels_q    <= '0;
         nmi_cause_q <= '0;
      end else begin
         levels_q <= levels_d;
         if (new_ret && nmi_hit) begin
            nmi_cause_q <= retire.intr.cause;
         end
      end
   end

   assign levels    = levels_q;
   assign nmi_cause = nmi_cause_q;

   // An accepted retirement shows up on the trace with its own order
   a_trace_after_new_ret: assert property (
      @(posedge rvvi) disable iff (!arst_n)
      new_ret |=> trace.valid && (trace.order == $past(retire.order))
   );

endmodule

// File: verilog/rvvi_pkg.sv
// Single hart with one destination register per retirement; RVFI halt and cause_type are not carried
`include "rvvi_cfg.svh"

package rvvi_pkg;

   //////////////////////////////
   // Enumerations

   // Net numbering, local interrupts follow NET_LOCAL_IRQ_BASE
   typedef enum logic [`RVVI_NET_ID_W-1:0] {
      NET_NMI            = 0,
      NET_IBUS_FAULT     = 1,
      NET_HALTREQ        = 2,
      NET_MSW_IRQ        = 3,
      NET_MTIMER_IRQ     = 4,
      NET_MEXT_IRQ       = 5,
      NET_LOCAL_IRQ_BASE = 6
   } net_id_e;

   // Debug entry causes as reported in rvfi_dbg
   typedef enum logic [2:0] {
      DBG_CAUSE_NONE    = 3'd0,
      DBG_CAUSE_EBREAK  = 3'd1,
      DBG_CAUSE_TRIGGER = 3'd2,
      DBG_CAUSE_HALTREQ = 3'd3,
      DBG_CAUSE_STEP    = 3'd4
   } dbg_cause_e;

   //////////////////////////////
   // RVFI side

   typedef struct packed {
      logic                         trap;
      logic                         exception;
      logic                         debug;
      logic [`RVVI_EXC_CAUSE_W-1:0] exception_cause;
   } rvfi_trap_t;

   typedef struct packed {
      logic                          intr;
      logic                          interrupt;
      logic [`RVVI_INTR_CAUSE_W-1:0] cause;
   } rvfi_intr_t;

   // Kept as plain bits so any value can be driven, compared against dbg_cause_e
   typedef struct packed {
      logic                     valid;
      logic [`RVVI_ORDER_W-1:0] order;
      logic [31:0]              insn;
      rvfi_trap_t               trap;
      rvfi_intr_t               intr;
      logic [1:0]               nmip;
      logic [2:0]               dbg;
      logic                     dbg_mode;
      logic [1:0]               mode;
      logic [1:0]               ixl;
      logic [`RVVI_XLEN-1:0]    pc_rdata;
      logic [`RVVI_XLEN-1:0]    pc_wdata;
      logic [4:0]               rd1_addr;
      logic [`RVVI_XLEN-1:0]    rd1_wdata;
   } rvfi_retire_t;

   //////////////////////////////
   // RVVI side

   typedef struct packed {
      logic                     valid;
      logic [`RVVI_ORDER_W-1:0] order;
      logic [31:0]              insn;
      logic                     trap;
      logic                     intr;
      logic [1:0]               mode;
      logic [1:0]               ixl;
      logic [`RVVI_XLEN-1:0]    pc_rdata;
      logic [`RVVI_XLEN-1:0]    pc_wdata;
      // One bit per GPR, x0 never set
      logic [31:0]              x_wb;
      logic [`RVVI_XLEN-1:0]    x_wdata;
   } rvvi_trace_t;

   typedef struct packed {
      logic                      valid;
      logic [`RVVI_NET_ID_W-1:0] id;
      logic                      level;
   } net_event_t;

endpackage

// File: verilog/rvvi_cfg.svh
// RV32 widths only; RVVI_NUM_LOCAL_IRQ must stay within 0 to 16 so local IRQs fit in irq[31:16]
`ifndef RVVI_CFG_SVH
`define RVVI_CFG_SVH

//////////////////////////////
// Datapath widths
`define RVVI_XLEN             32
`define RVVI_ORDER_W          64
`define RVVI_EXC_CAUSE_W      6
`define RVVI_INTR_CAUSE_W     11

//////////////////////////////
// Cause codes seen on RVFI
`define RVVI_IBUS_FAULT_CAUSE 48
`define RVVI_NMI_LOAD_CAUSE   1024
`define RVVI_NMI_STORE_CAUSE  1025

//////////////////////////////
// Net counts
`define RVVI_NUM_LOCAL_IRQ    4

// NMI, bus fault and halt request, then the three machine interrupts
`define RVVI_NUM_NETS         (6 + `RVVI_NUM_LOCAL_IRQ)
`define RVVI_NET_ID_W         ($clog2(`RVVI_NUM_NETS))

`endif
